/* dm_top.f */
source/dm_dmi_pkg.sv
source/dm_reg_pkg.sv
source/dm_dmi_frontend.sv
source/dm_reg_decode.sv
source/dm_control_regs.sv
source/dm_data_regs.sv
source/dm_top.sv
testbench/dm_top_tb.sv

/* Bender.yml */
package:
  name: dm_top

sources:
  - source/dm_dmi_pkg.sv
  - source/dm_reg_pkg.sv
  - source/dm_dmi_frontend.sv
  - source/dm_reg_decode.sv
  - source/dm_control_regs.sv
  - source/dm_data_regs.sv
  - source/dm_top.sv
  - target: test
    files:
      - testbench/dm_top_tb.sv

/* testbench/dm_top_tb.sv */
`timescale 1ns/1ps

module dm_top_tb;
    import dm_dmi_pkg::*;
    import dm_reg_pkg::*;

    localparam dmi_addr_t addr_abstractcs = 7'h16;
    localparam dmi_addr_t addr_sbcs       = 7'h38;
    localparam int        resp_timeout    = 40;

    logic         dm_clk;
    logic         dm_rst_n;
    logic         dm_core_rst_n;
    hart_status_t hart;
    logic         halt_req;
    logic         hartreset;
    logic         ndmreset;
    logic         dtm2dm_empty;
    dmi_frame_t   dtm2dm_data_out;
    logic         dtm2dm_ren;
    logic         dm2dtm_full;
    logic         dm2dtm_wen;
    dmi_frame_t   dm2dtm_data_in;

    dmi_frame_t  req_q[$];
    logic [31:0] lfsr_state = 32'hc916_f1be;
    int          error_count = 0;
    int          timeout_count = 0;

    dm_top dm_top_inst (
        .dm_clk          (dm_clk),
        .dm_rst_n        (dm_rst_n),
        .dm_core_rst_n   (dm_core_rst_n),
        .hart            (hart),
        .halt_req        (halt_req),
        .hartreset       (hartreset),
        .ndmreset        (ndmreset),
        .dtm2dm_empty    (dtm2dm_empty),
        .dtm2dm_data_out (dtm2dm_data_out),
        .dtm2dm_ren      (dtm2dm_ren),
        .dm2dtm_full     (dm2dtm_full),
        .dm2dtm_wen      (dm2dtm_wen),
        .dm2dtm_data_in  (dm2dtm_data_in)
    );

    always #4 dm_clk = ~dm_clk;

    // Request FIFO model, first word fall through. The head word is dropped on ren.
    always @(posedge dm_clk) begin
        if (dtm2dm_ren && req_q.size() > 0) begin
            void'(req_q.pop_front());
        end
        dtm2dm_empty <= req_q.size() == 0;
        if (req_q.size() > 0) begin
            dtm2dm_data_out <= req_q[0];
        end
    end

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic random_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    function automatic dmi_frame_t make_frame(dmi_addr_t addr, logic [31:0] data, logic [1:0] op);
        dmi_frame_t f;
        f.addr = addr;
        f.data = data;
        f.op   = op;
        return f;
    endfunction

    // The dmstatus image for a single hart, as the debug spec lays it out.
    function automatic logic [31:0] expected_status(logic halted, logic resumeack,
                                                    logic havereset, logic ndm);
        logic [31:0] s;
        s        = '0;
        s[3:0]   = 4'd2;
        s[7]     = 1'b1;
        s[9:8]   = {2{halted}};
        s[11:10] = {2{!halted}};
        s[17:16] = {2{resumeack}};
        s[19:18] = {2{havereset}};
        s[24]    = ndm;
        return s;
    endfunction

    task automatic check_frame(input string name, input dmi_frame_t got, input dmi_frame_t exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR %s: got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic send_frame(input logic [1:0] op, input dmi_addr_t addr,
                              input logic [31:0] data);
        @(negedge dm_clk);
        req_q.push_back(make_frame(addr, data, op));
    endtask

    task automatic get_response(output dmi_frame_t f);
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        f      = '0;
        while (!seen && cycles < resp_timeout) begin
            @(posedge dm_clk);
            cycles++;
            if (dm2dtm_wen) begin
                f    = dm2dtm_data_in;
                seen = 1'b1;
            end
        end
        if (!seen) begin
            $display("No response frame arrived within %0d cycles", resp_timeout);
            timeout_count++;
        end
    endtask

    task automatic run_access(input logic [1:0] op, input dmi_addr_t addr, input logic [31:0] data,
                              input dmi_frame_t exp, input string name);
        dmi_frame_t f;
        send_frame(op, addr, data);
        get_response(f);
        check_frame(name, f, exp);
    endtask

    task automatic test_reset_state();
        @(posedge dm_clk);
        check_bit("halt_req", halt_req, 1'b0);
        check_bit("hartreset", hartreset, 1'b0);
        check_bit("ndmreset", ndmreset, 1'b0);
        check_bit("dtm2dm_ren", dtm2dm_ren, 1'b0);
        check_bit("dm2dtm_wen", dm2dtm_wen, 1'b0);
        run_access(dmi_op_read, dm_addr_dmstatus, 32'h0,
                   make_frame(dm_addr_dmstatus, expected_status(0, 0, 1, 0), dmi_resp_ok),
                   "dmstatus_after_reset");
    endtask

    task automatic test_storage();
        logic [31:0] words [4];
        dmi_addr_t   addrs [4];
        addrs[0] = dm_addr_data0;
        addrs[1] = dm_addr_data0 + 7'd1;
        addrs[2] = dm_addr_progbuf0;
        addrs[3] = dm_addr_progbuf0 + 7'd1;
        for (int i = 0; i < 4; i++) begin
            random_word(words[i]);
            run_access(dmi_op_write, addrs[i], words[i],
                       make_frame(addrs[i], words[i], dmi_resp_ok), "store_write_resp");
        end
        for (int i = 0; i < 4; i++) begin
            run_access(dmi_op_read, addrs[i], 32'h0,
                       make_frame(addrs[i], words[i], dmi_resp_ok), "store_read_resp");
        end
    endtask

    task automatic test_dmcontrol();
        run_access(dmi_op_write, dm_addr_dmcontrol, 32'ha000_0003,
                   make_frame(dm_addr_dmcontrol, 32'ha000_0003, dmi_resp_ok), "dmcontrol_write");
        check_bit("halt_req", halt_req, 1'b1);
        check_bit("hartreset", hartreset, 1'b1);
        check_bit("ndmreset", ndmreset, 1'b1);
        run_access(dmi_op_read, dm_addr_dmcontrol, 32'h0,
                   make_frame(dm_addr_dmcontrol, 32'ha000_0003, dmi_resp_ok), "dmcontrol_read");
        run_access(dmi_op_read, dm_addr_dmstatus, 32'h0,
                   make_frame(dm_addr_dmstatus, expected_status(0, 0, 1, 1), dmi_resp_ok),
                   "dmstatus_ndmreset");
        // Requests written along with dmactive 0 must not take effect.
        run_access(dmi_op_write, dm_addr_dmcontrol, 32'ha000_0002,
                   make_frame(dm_addr_dmcontrol, 32'ha000_0002, dmi_resp_ok), "dmcontrol_clear");
        check_bit("halt_req", halt_req, 1'b0);
        check_bit("hartreset", hartreset, 1'b0);
        check_bit("ndmreset", ndmreset, 1'b0);
        run_access(dmi_op_read, dm_addr_dmcontrol, 32'h0,
                   make_frame(dm_addr_dmcontrol, 32'h0, dmi_resp_ok), "dmcontrol_read_cleared");
    endtask

    task automatic test_status_tracking();
        @(posedge dm_clk);
        hart.halted    <= 1'b1;
        hart.resumeack <= 1'b1;
        run_access(dmi_op_read, dm_addr_dmstatus, 32'h0,
                   make_frame(dm_addr_dmstatus, expected_status(1, 1, 1, 0), dmi_resp_ok),
                   "dmstatus_halted");
        run_access(dmi_op_write, dm_addr_dmcontrol, 32'h1000_0001,
                   make_frame(dm_addr_dmcontrol, 32'h1000_0001, dmi_resp_ok), "ackhavereset");
        run_access(dmi_op_read, dm_addr_dmstatus, 32'h0,
                   make_frame(dm_addr_dmstatus, expected_status(1, 1, 0, 0), dmi_resp_ok),
                   "dmstatus_acked");
        @(posedge dm_clk);
        dm_core_rst_n <= 1'b0;
        repeat (2) @(posedge dm_clk);
        dm_core_rst_n <= 1'b1;
        hart.halted    <= 1'b0;
        hart.resumeack <= 1'b0;
        run_access(dmi_op_read, dm_addr_dmstatus, 32'h0,
                   make_frame(dm_addr_dmstatus, expected_status(0, 0, 1, 0), dmi_resp_ok),
                   "dmstatus_core_reset");
    endtask

    task automatic test_error_cases();
        logic [31:0] w;
        random_word(w);
        run_access(dmi_op_read, addr_abstractcs, 32'h0,
                   make_frame(addr_abstractcs, 32'h0, dmi_resp_failed), "abstractcs_read");
        run_access(dmi_op_write, dm_addr_dmstatus, w,
                   make_frame(dm_addr_dmstatus, w, dmi_resp_failed), "dmstatus_write");
        run_access(dmi_op_write, addr_sbcs, w,
                   make_frame(addr_sbcs, w, dmi_resp_failed), "sbcs_write");
        run_access(dmi_op_read, dm_addr_hartinfo, 32'h0,
                   make_frame(dm_addr_hartinfo, 32'h0, dmi_resp_ok), "hartinfo_read");
        run_access(dmi_op_nop, dm_addr_data0, w, '0, "nop_resp");
        run_access(dmi_op_rsvd, dm_addr_dmcontrol, w, '0, "reserved_op_resp");
    endtask

    task automatic test_backpressure();
        logic [31:0] w;
        dmi_frame_t  f;
        int          wen_seen;
        wen_seen = 0;
        random_word(w);
        @(posedge dm_clk);
        dm2dtm_full <= 1'b1;
        send_frame(dmi_op_write, dm_addr_data0 + 7'd1, w);
        send_frame(dmi_op_read, dm_addr_data0 + 7'd1, 32'h0);
        repeat (12) begin
            @(posedge dm_clk);
            if (dm2dtm_wen) begin
                wen_seen++;
            end
        end
        if (wen_seen != 0) begin
            $display("A response was written %0d times while the FIFO was full", wen_seen);
            error_count++;
        end
        if (req_q.size() != 1) begin
            $display("ERROR req_queue_depth: got %h expected %h", req_q.size(), 1);
            error_count++;
        end
        dm2dtm_full <= 1'b0;
        get_response(f);
        check_frame("held_write_resp", f, make_frame(dm_addr_data0 + 7'd1, w, dmi_resp_ok));
        get_response(f);
        check_frame("queued_read_resp", f, make_frame(dm_addr_data0 + 7'd1, w, dmi_resp_ok));
    endtask

    initial begin
        dm_clk          = 1'b0;
        dm_rst_n        = 1'b0;
        dm_core_rst_n   = 1'b0;
        hart            = '0;
        dtm2dm_empty    = 1'b1;
        dtm2dm_data_out = '0;
        dm2dtm_full     = 1'b0;
        repeat (4) @(posedge dm_clk);
        dm_rst_n      <= 1'b1;
        dm_core_rst_n <= 1'b1;

        test_reset_state();
        test_storage();
        test_dmcontrol();
        test_status_tracking();
        test_error_cases();
        test_backpressure();

        $display("Value errors: %0d, timeouts: %0d", error_count, timeout_count);
        if (error_count == 0 && timeout_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

/* source/dm_top.sv */
`timescale 1ns/1ps

module dm_top (
    input  logic                     dm_clk,
    input  logic                     dm_rst_n,
    input  logic                     dm_core_rst_n,
    input  dm_reg_pkg::hart_status_t hart,
    output logic                     halt_req,
    output logic                     hartreset,
    output logic                     ndmreset,
    input  logic                     dtm2dm_empty,
    input  dm_dmi_pkg::dmi_frame_t   dtm2dm_data_out,
    output logic                     dtm2dm_ren,
    input  logic                     dm2dtm_full,
    output logic                     dm2dtm_wen,
    output dm_dmi_pkg::dmi_frame_t   dm2dtm_data_in
);
    import dm_reg_pkg::*;

    dm_reg_acc_t reg_acc;
    dm_reg_wr_t  wr;
    logic [31:0] wr_data;
    logic [31:0] rd_data;
    logic        rd_ok;
    logic        wr_ok;
    logic [31:0] ctl_rd;
    logic [31:0] status_rd;
    logic [31:0] store_rd;

    dm_dmi_frontend frontend_inst (
        .dm_clk          (dm_clk),
        .dm_rst_n        (dm_rst_n),
        .dtm2dm_empty    (dtm2dm_empty),
        .dtm2dm_data_out (dtm2dm_data_out),
        .dtm2dm_ren      (dtm2dm_ren),
        .dm2dtm_full     (dm2dtm_full),
        .dm2dtm_wen      (dm2dtm_wen),
        .dm2dtm_data_in  (dm2dtm_data_in),
        .reg_acc         (reg_acc),
        .rd_data         (rd_data),
        .rd_ok           (rd_ok),
        .wr_ok           (wr_ok)
    );

    dm_reg_decode decode_inst (
        .reg_acc   (reg_acc),
        .ctl_rd    (ctl_rd),
        .status_rd (status_rd),
        .store_rd  (store_rd),
        .wr        (wr),
        .wr_data   (wr_data),
        .rd_data   (rd_data),
        .rd_ok     (rd_ok),
        .wr_ok     (wr_ok)
    );

    dm_control_regs control_inst (
        .dm_clk        (dm_clk),
        .dm_rst_n      (dm_rst_n),
        .dm_core_rst_n (dm_core_rst_n),
        .wr            (wr),
        .wr_data       (wr_data),
        .hart          (hart),
        .halt_req      (halt_req),
        .hartreset     (hartreset),
        .ndmreset      (ndmreset),
        .ctl_rd        (ctl_rd),
        .status_rd     (status_rd)
    );

    // The store index is decoded from the address, so it selects the read word as well.
    dm_data_regs data_inst (
        .dm_clk   (dm_clk),
        .dm_rst_n (dm_rst_n),
        .wr       (wr),
        .wr_data  (wr_data),
        .rd_index (wr.store_idx),
        .store_rd (store_rd)
    );

endmodule

/* source/dm_data_regs.sv */
`timescale 1ns/1ps

module dm_data_regs (
    input  logic                   dm_clk,
    input  logic                   dm_rst_n,
    input  dm_reg_pkg::dm_reg_wr_t wr,
    input  logic [31:0]            wr_data,
    input  logic [1:0]             rd_index,
    output logic [31:0]            store_rd
);
    import dm_reg_pkg::*;

    // Words 0 and 1 are data0 and data1, words 2 and 3 the program buffer.
    logic [31:0] store_q [dm_num_data + dm_num_progbuf];

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            for (int i = 0; i < dm_num_data + dm_num_progbuf; i++) begin
                store_q[i] <= '0;
            end
        end else if (wr.we_store) begin
            store_q[wr.store_idx] <= wr_data;
        end
    end

    assign store_rd = store_q[rd_index];

endmodule

/* source/dm_control_regs.sv */
`timescale 1ns/1ps

module dm_control_regs (
    input  logic                     dm_clk,
    input  logic                     dm_rst_n,
    input  logic                     dm_core_rst_n,
    input  dm_reg_pkg::dm_reg_wr_t   wr,
    input  logic [31:0]              wr_data,
    input  dm_reg_pkg::hart_status_t hart,
    output logic                     halt_req,
    output logic                     hartreset,
    output logic                     ndmreset,
    output logic [31:0]              ctl_rd,
    output logic [31:0]              status_rd
);
    import dm_reg_pkg::*;

    logic dmactive;
    logic havereset;
    logic havereset_set_n;
    logic ack_havereset;

    // Writing dmactive as 0 drops every request along with it.
    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            dmactive  <= 1'b0;
            halt_req  <= 1'b0;
            hartreset <= 1'b0;
            ndmreset  <= 1'b0;
        end else if (wr.we_dmcontrol) begin
            dmactive  <= wr_data[dm_ctl_dmactive];
            halt_req  <= wr_data[dm_ctl_dmactive] & wr_data[dm_ctl_haltreq];
            hartreset <= wr_data[dm_ctl_dmactive] & wr_data[dm_ctl_hartreset];
            ndmreset  <= wr_data[dm_ctl_dmactive] & wr_data[dm_ctl_ndmreset];
        end
    end

    // A core reset sets havereset; the debug module reset does too so it starts out set.
    assign havereset_set_n = dm_rst_n & dm_core_rst_n;
    assign ack_havereset   = wr.we_dmcontrol & wr_data[dm_ctl_ackhavereset] &
                             wr_data[dm_ctl_dmactive];

    always_ff @(posedge dm_clk or negedge havereset_set_n) begin
        if (!havereset_set_n) begin
            havereset <= 1'b1;
        end else if (ack_havereset) begin
            havereset <= 1'b0;
        end
    end

    always_comb begin
        ctl_rd                      = '0;
        ctl_rd[dm_ctl_haltreq]      = halt_req;
        ctl_rd[dm_ctl_hartreset]    = hartreset;
        ctl_rd[dm_ctl_ndmreset]     = ndmreset;
        ctl_rd[dm_ctl_dmactive]     = dmactive;
    end

    // With a single hart the any and all flags are the same bit.
    always_comb begin
        status_rd        = '0;
        status_rd[3:0]   = dm_debug_version;
        status_rd[7]     = 1'b1;  // Authenticated.
        status_rd[9:8]   = {2{hart.halted}};
        status_rd[11:10] = {2{~hart.halted}};
        status_rd[17:16] = {2{hart.resumeack}};
        status_rd[19:18] = {2{havereset}};
        status_rd[24]    = ndmreset;  // Reset stays pending while ndmreset is held.
    end

endmodule

/* source/dm_reg_decode.sv */
`timescale 1ns/1ps

module dm_reg_decode (
    input  dm_reg_pkg::dm_reg_acc_t reg_acc,
    input  logic [31:0]             ctl_rd,
    input  logic [31:0]             status_rd,
    input  logic [31:0]             store_rd,
    output dm_reg_pkg::dm_reg_wr_t  wr,
    output logic [31:0]             wr_data,
    output logic [31:0]             rd_data,
    output logic                    rd_ok,
    output logic                    wr_ok
);
    import dm_reg_pkg::*;

    logic sel_ctl;
    logic sel_status;
    logic sel_hartinfo;
    logic sel_data;
    logic sel_progbuf;
    logic sel_store;

    assign sel_ctl      = reg_acc.addr == dm_addr_dmcontrol;
    assign sel_status   = reg_acc.addr == dm_addr_dmstatus;
    assign sel_hartinfo = reg_acc.addr == dm_addr_hartinfo;
    assign sel_data     = (reg_acc.addr >= dm_addr_data0) &&
                          (reg_acc.addr < dm_addr_data0 + dm_num_data);
    assign sel_progbuf  = (reg_acc.addr >= dm_addr_progbuf0) &&
                          (reg_acc.addr < dm_addr_progbuf0 + dm_num_progbuf);
    assign sel_store    = sel_data || sel_progbuf;

    // Abstract command and system bus addresses fall outside every select and fail.
    assign rd_ok = sel_ctl || sel_status || sel_hartinfo || sel_store;
    assign wr_ok = sel_ctl || sel_store;

    assign wr_data = reg_acc.data;

    always_comb begin
        wr.we_dmcontrol = reg_acc.we && sel_ctl;
        wr.we_store     = reg_acc.we && sel_store;
        if (sel_progbuf) begin
            wr.store_idx = 2'(dm_num_data) + 2'(reg_acc.addr - dm_addr_progbuf0);
        end else begin
            wr.store_idx = 2'(reg_acc.addr - dm_addr_data0);
        end
    end

    // Hartinfo has nothing to report and reads as zero, like any unknown address.
    always_comb begin
        rd_data = '0;
        if (reg_acc.re) begin
            if (sel_ctl) begin
                rd_data = ctl_rd;
            end else if (sel_status) begin
                rd_data = status_rd;
            end else if (sel_store) begin
                rd_data = store_rd;
            end
        end
    end

endmodule

/* source/dm_dmi_frontend.sv */
`timescale 1ns/1ps

module dm_dmi_frontend (
    input  logic                    dm_clk,
    input  logic                    dm_rst_n,
    input  logic                    dtm2dm_empty,
    input  dm_dmi_pkg::dmi_frame_t  dtm2dm_data_out,
    output logic                    dtm2dm_ren,
    input  logic                    dm2dtm_full,
    output logic                    dm2dtm_wen,
    output dm_dmi_pkg::dmi_frame_t  dm2dtm_data_in,
    output dm_reg_pkg::dm_reg_acc_t reg_acc,
    input  logic [31:0]             rd_data,
    input  logic                    rd_ok,
    input  logic                    wr_ok
);
    import dm_dmi_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_judge,
        st_access,
        st_respond
    } state_t;

    state_t     state_q;
    dmi_frame_t frame_q;
    dmi_frame_t resp_q;
    logic       is_read;
    logic       is_write;
    logic [1:0] resp_op;

    assign is_read  = frame_q.op == dmi_op_read;
    assign is_write = frame_q.op == dmi_op_write;

    // Only one transaction is in flight, so a new word is popped from idle alone.
    assign dtm2dm_ren     = (state_q == st_idle) && !dtm2dm_empty;
    assign dm2dtm_wen     = (state_q == st_respond) && !dm2dtm_full;
    assign dm2dtm_data_in = resp_q;

    always_comb begin
        reg_acc.we   = (state_q == st_access) && is_write;
        reg_acc.re   = (state_q == st_access) && is_read;
        reg_acc.addr = frame_q.addr;
        reg_acc.data = frame_q.data;
    end

    always_comb begin
        if (is_read) begin
            resp_op = rd_ok ? dmi_resp_ok : dmi_resp_failed;
        end else begin
            resp_op = wr_ok ? dmi_resp_ok : dmi_resp_failed;
        end
    end

    always_ff @(posedge dm_clk or negedge dm_rst_n) begin
        if (!dm_rst_n) begin
            state_q <= st_idle;
        end else begin
            case (state_q)
                st_idle: begin
                    if (dtm2dm_ren) begin
                        state_q <= st_judge;
                    end
                end
                st_judge: begin
                    case (frame_q.op)
                        dmi_op_read, dmi_op_write: state_q <= st_access;
                        dmi_op_nop, dmi_op_rsvd:   state_q <= st_respond;
                        default:                   state_q <= st_idle;
                    endcase
                end
                st_access: state_q <= st_respond;
                st_respond: begin
                    if (!dm2dtm_full) begin
                        state_q <= st_idle;  // Held here while the response FIFO is full.
                    end
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    always_ff @(posedge dm_clk) begin
        if (dtm2dm_ren) begin
            frame_q <= dtm2dm_data_out;
        end
        if (state_q == st_judge && !(is_read || is_write)) begin
            resp_q <= dmi_frame_t'({dmi_frame_w{1'b0}});  // Nop and reserved ops answer all zero.
        end else if (state_q == st_access) begin
            resp_q.addr <= frame_q.addr;
            resp_q.data <= is_read ? rd_data : frame_q.data;
            resp_q.op   <= resp_op;
        end
    end

endmodule

/* source/dm_reg_pkg.sv */
package dm_reg_pkg;

    // Register addresses inside the debug module.
    localparam dm_dmi_pkg::dmi_addr_t dm_addr_data0     = 7'h04;
    localparam dm_dmi_pkg::dmi_addr_t dm_addr_dmcontrol = 7'h10;
    localparam dm_dmi_pkg::dmi_addr_t dm_addr_dmstatus  = 7'h11;
    localparam dm_dmi_pkg::dmi_addr_t dm_addr_hartinfo  = 7'h12;
    localparam dm_dmi_pkg::dmi_addr_t dm_addr_progbuf0  = 7'h20;

    localparam int dm_num_data    = 2;
    localparam int dm_num_progbuf = 2;

    localparam logic [3:0] dm_debug_version = 4'd2;  // Debug spec 0.13.

    // Bit positions in dmcontrol.
    localparam int dm_ctl_haltreq      = 31;
    localparam int dm_ctl_hartreset    = 29;
    localparam int dm_ctl_ackhavereset = 28;
    localparam int dm_ctl_ndmreset     = 1;
    localparam int dm_ctl_dmactive     = 0;

    // One register access, valid for a single cycle when we or re is set.
    typedef struct packed {
        logic                  we;
        logic                  re;
        dm_dmi_pkg::dmi_addr_t addr;
        logic [31:0]           data;
    } dm_reg_acc_t;

    typedef struct packed {
        logic       we_dmcontrol;
        logic       we_store;
        logic [1:0] store_idx;  // Data words first, then the program buffer.
    } dm_reg_wr_t;

    typedef struct packed {
        logic halted;
        logic resumeack;
    } hart_status_t;

endpackage

/* source/dm_dmi_pkg.sv */
package dm_dmi_pkg;

    localparam int dmi_abits   = 7;
    localparam int dmi_frame_w = dmi_abits + 34;  // Address, 32 data bits and the op.

    typedef logic [dmi_abits-1:0] dmi_addr_t;

    // The same layout is used for requests from the DTM and responses back to it.
    typedef struct packed {
        dmi_addr_t   addr;
        logic [31:0] data;
        logic [1:0]  op;
    } dmi_frame_t;

    // Request op codes.
    localparam logic [1:0] dmi_op_nop   = 2'd0;
    localparam logic [1:0] dmi_op_read  = 2'd1;
    localparam logic [1:0] dmi_op_write = 2'd2;
    localparam logic [1:0] dmi_op_rsvd  = 2'd3;

    // Response status codes. Busy (3) is never returned since accesses finish in one cycle.
    localparam logic [1:0] dmi_resp_ok     = 2'd0;
    localparam logic [1:0] dmi_resp_failed = 2'd2;

endpackage
